// ==== tge_write_packetizer.f ====
+incdir+hdl
hdl/tge_pkg.sv
hdl/sample_fifo.sv
hdl/word_serializer.sv
hdl/tx_framer.sv
hdl/tge_write_packetizer.sv
verification/tge_write_packetizer_chk.sv
verification/tb_tge_write_packetizer.sv

// ==== Makefile ====
TOP             ?= tb_tge_write_packetizer
FILELIST        ?= tge_write_packetizer.f
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert
FAIL_MSG        := Finished with errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "Variables: TOP FILELIST LOG OBJ_DIR VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_tge_write_packetizer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "tge_defs.svh"

module tb_tge_write_packetizer;

    import tge_pkg::*;

    localparam int DIN_W     = `TGE_DIN_WIDTH;
    localparam int TX_W      = `TGE_TX_WIDTH;
    localparam int NUM_BEATS = DIN_W / TX_W;
    localparam int DEPTH     = `TGE_FIFO_DEPTH;
    localparam int TIMEOUT   = 5000;

    logic             clk;
    logic             rst;
    logic [DIN_W-1:0] din;
    logic             din_valid;
    cfg_word_t        pkt_len;
    cfg_word_t        sleep_cycles;
    ip_addr_t         config_tx_dest_ip;
    cfg_word_t        config_tx_dest_port;
    tx_word_t         tx_data;
    logic             tx_valid;
    ip_addr_t         tx_dest_ip;
    udp_port_t        tx_dest_port;
    logic             tx_eof;
    logic             fifo_full;

    // expected beats in output order
    tx_word_t    exp_q[$];
    logic [31:0] rng_state;
    string       current_test;
    int          writes_accepted;
    int          words_popped;
    int          beats_seen;
    int          beats_in_pkt;
    int          idle_cycles;
    logic        eof_seen;
    logic        run_passed;
    logic        failure_reported;

    tge_write_packetizer dut_i (
        .clk                 (clk),
        .rst                 (rst),
        .din                 (din),
        .din_valid           (din_valid),
        .pkt_len             (pkt_len),
        .sleep_cycles        (sleep_cycles),
        .config_tx_dest_ip   (config_tx_dest_ip),
        .config_tx_dest_port (config_tx_dest_port),
        .tx_data             (tx_data),
        .tx_valid            (tx_valid),
        .tx_dest_ip          (tx_dest_ip),
        .tx_dest_port        (tx_dest_port),
        .tx_eof              (tx_eof),
        .fifo_full           (fifo_full)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        failure_reported = 1'b1;
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h",
                     current_test, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic timeout_failure(input string what);
        $display("timeout in %s while waiting for %s", current_test, what);
        stop_with_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_word(output logic [DIN_W-1:0] w);
        for (int j = 0; j < DIN_W / 32; j++) begin
            rng_state = xorshift32(rng_state);
            w[j*32 +: 32] = rng_state;
        end
    endtask

    // reference model, low 64 bits leave first
    function automatic void split_into_beats(input logic [DIN_W-1:0] w);
        logic [DIN_W-1:0] rest;
        rest = w;
        for (int i = 0; i < NUM_BEATS; i++) begin
            exp_q.push_back(rest[TX_W-1:0]);
            rest = rest >> TX_W;
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset(input cfg_word_t len, input cfg_word_t gap,
                               input ip_addr_t ip, input cfg_word_t port);
        if (exp_q.size() != 0) begin
            $display("%s left %0d expected beats that never came out",
                     current_test, exp_q.size());
            stop_with_failure();
        end
        rst                 = 1'b1;
        din_valid           = 1'b0;
        din                 = '0;
        pkt_len             = len;
        sleep_cycles        = gap;
        config_tx_dest_ip   = ip;
        config_tx_dest_port = port;
        writes_accepted     = 0;
        words_popped        = 0;
        beats_seen          = 0;
        repeat (2) next_cycle();
        rst = 1'b0;
    endtask

    // acceptance follows the modelled FIFO occupancy
    task automatic write_word(input logic [DIN_W-1:0] w);
        din       = w;
        din_valid = 1'b1;
        if (writes_accepted - words_popped < DEPTH) begin
            split_into_beats(w);
            writes_accepted++;
        end
        next_cycle();
        din_valid = 1'b0;
    endtask

    // paced so the link keeps up
    task automatic stream_words(input int count);
        logic [DIN_W-1:0] w;
        int               waited;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            while (writes_accepted - words_popped >= 3) begin
                next_cycle();
                waited++;
                if (waited > TIMEOUT) begin
                    timeout_failure("room in the FIFO");
                end
            end
            rng_state = xorshift32(rng_state);
            repeat (rng_state[1:0]) next_cycle();
            random_word(w);
            write_word(w);
        end
    endtask

    task automatic drain_expected();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                timeout_failure("the expected beats");
            end
        end
        // long enough for one more packet to show up if one were pending
        repeat (int'(sleep_cycles) + 2 * NUM_BEATS + 8) next_cycle();
    endtask

    task automatic run_stream_test(input string name, input cfg_word_t len,
                                   input cfg_word_t gap, input ip_addr_t ip,
                                   input cfg_word_t port, input int count);
        current_test = name;
        apply_reset(len, gap, ip, port);
        stream_words(count);
        drain_expected();
    endtask

    always @(negedge clk) begin : compare_outputs
        tx_word_t expected_beat;
        logic     eof_expected;
        if (rst) begin
            beats_in_pkt = 0;
            idle_cycles  = 0;
            eof_seen     = 1'b0;
        end else begin
            check_value("tx_dest_ip", 64'(config_tx_dest_ip), 64'(tx_dest_ip));
            check_value("tx_dest_port", 64'(config_tx_dest_port[15:0]), 64'(tx_dest_port));
            if (tx_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s produced a beat that no accepted word accounts for",
                             current_test);
                    stop_with_failure();
                end else begin
                    expected_beat = exp_q.pop_front();
                    check_value("tx_data", 64'(expected_beat), 64'(tx_data));
                end
                if (eof_seen && cfg_word_t'(idle_cycles) <= sleep_cycles) begin
                    $display("FAILED %s sleep gap: expected at least %0d, actual %0d",
                             current_test, sleep_cycles + 32'd1, idle_cycles);
                    stop_with_failure();
                end
                beats_in_pkt++;
                eof_expected = (cfg_word_t'(beats_in_pkt) == pkt_len + 32'd1);
                check_value("tx_eof", 64'(eof_expected), 64'(tx_eof));
                beats_seen++;
                if (beats_seen % NUM_BEATS == 0) begin
                    words_popped++;
                end
                if (tx_eof) begin
                    beats_in_pkt = 0;
                    idle_cycles  = 0;
                    eof_seen     = 1'b1;
                end
            end else begin
                check_value("tx_eof without tx_valid", 64'd0, 64'(tx_eof));
                idle_cycles++;
            end
        end
    end

    initial begin
        logic [DIN_W-1:0] w;
        clk                 = 1'b0;
        rst                 = 1'b1;
        din                 = '0;
        din_valid           = 1'b0;
        pkt_len             = '0;
        sleep_cycles        = '0;
        config_tx_dest_ip   = '0;
        config_tx_dest_port = '0;
        rng_state           = 32'h74e0_5dea;
        run_passed          = 1'b0;
        failure_reported    = 1'b0;
        current_test        = "startup";

        run_stream_test("order_len3_gap2", 32'd3, 32'd2, 32'hc0a8_0a01, 32'h0000_1f90, 24);
        run_stream_test("len0_gap0", 32'd0, 32'd0, 32'h0a00_0002, 32'hffff_2710, 24);
        run_stream_test("len7_gap5", 32'd7, 32'd5, 32'hac10_0005, 32'hdead_beef, 24);
        run_stream_test("len0_gap5", 32'd0, 32'd5, 32'he000_00fb, 32'h8000_14e9, 24);

        // framer asleep while the FIFO overfills
        current_test = "overflow";
        apply_reset(32'd7, 32'd50, 32'hc633_6407, 32'h5a5a_0401);
        for (int i = 0; i < DEPTH + 3; i++) begin
            random_word(w);
            write_word(w);
        end
        check_value("fifo_full", 64'd1, 64'(fifo_full));
        drain_expected();
        check_value("fifo_full after drain", 64'd0, 64'(fifo_full));

        if (!failure_reported) begin
            run_passed = 1'b1;
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

    // a run cut short by an assertion still ends with a verdict
    final begin
        if (!run_passed && !failure_reported) begin
            $display("Finished with errors");
        end
    end

endmodule

`default_nettype wire

// ==== verification/tge_write_packetizer_chk.sv ====
`default_nettype none
`timescale 1ns/1ns

module tge_write_packetizer_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic tx_valid,
    input wire logic tx_eof,
    input wire logic fifo_full,
    input wire logic fifo_empty,
    input wire logic beat_ready
);

    // end of frame only rides on a valid beat
    property eof_needs_valid;
        @(posedge clk) disable iff (rst) tx_eof |-> tx_valid;
    endproperty

    // outputs quiet right after a reset cycle
    property quiet_after_reset;
        @(posedge clk) rst |=> (!tx_valid && !tx_eof && !beat_ready);
    endproperty

    // a full FIFO holds data
    property full_not_empty;
        @(posedge clk) disable iff (rst) fifo_full |-> !fifo_empty;
    endproperty

    a_eof_needs_valid: assert property (eof_needs_valid)
        else $error("tx_eof asserted without tx_valid");

    a_quiet_after_reset: assert property (quiet_after_reset)
        else $error("framer outputs active in the cycle after reset");

    a_full_not_empty: assert property (full_not_empty)
        else $error("FIFO reports full and empty at once");

endmodule

bind tge_write_packetizer tge_write_packetizer_chk chk_i (
    .clk        (clk),
    .rst        (rst),
    .tx_valid   (tx_valid),
    .tx_eof     (tx_eof),
    .fifo_full  (fifo_full),
    .fifo_empty (u_serializer.fifo_empty),
    .beat_ready (beat_ready)
);

`default_nettype wire

// ==== hdl/tge_write_packetizer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "tge_defs.svh"

module tge_write_packetizer #(
    parameter int DIN_WIDTH  = `TGE_DIN_WIDTH,
    parameter int FIFO_DEPTH = `TGE_FIFO_DEPTH
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [DIN_WIDTH-1:0] din,
    input  wire logic                 din_valid,
    input  tge_pkg::cfg_word_t        pkt_len,
    input  tge_pkg::cfg_word_t        sleep_cycles,
    input  tge_pkg::ip_addr_t         config_tx_dest_ip,
    input  tge_pkg::cfg_word_t        config_tx_dest_port,
    output tge_pkg::tx_word_t         tx_data,
    output logic                      tx_valid,
    output tge_pkg::ip_addr_t         tx_dest_ip,
    output tge_pkg::udp_port_t        tx_dest_port,
    output logic                      tx_eof,
    output logic                      fifo_full
);

    import tge_pkg::*;

    tx_word_t beat;
    logic     beat_valid;
    logic     beat_ready;

    // destination comes straight from configuration
    assign tx_dest_ip   = config_tx_dest_ip;
    assign tx_dest_port = config_tx_dest_port[15:0];

    word_serializer #(
        .DIN_WIDTH  (DIN_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_serializer (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .beat_ready (beat_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .fifo_full  (fifo_full)
    );

    tx_framer u_framer (
        .clk          (clk),
        .rst          (rst),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .pkt_len      (pkt_len),
        .sleep_cycles (sleep_cycles),
        .beat_ready   (beat_ready),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_eof       (tx_eof)
    );

endmodule

`default_nettype wire

// ==== hdl/tx_framer.sv ====
`default_nettype none
`timescale 1ns/1ns

module tx_framer (
    input  wire logic              clk,
    input  wire logic              rst,
    input  tge_pkg::tx_word_t      beat,
    input  wire logic              beat_valid,
    input  tge_pkg::cfg_word_t     pkt_len,
    input  tge_pkg::cfg_word_t     sleep_cycles,
    output logic                   beat_ready,
    output tge_pkg::tx_word_t      tx_data,
    output logic                   tx_valid,
    output logic                   tx_eof
);

    import tge_pkg::*;

    framer_state_t state;
    cfg_word_t     counter;
    logic          xfer;

    // beats are only pulled while a packet is open
    assign beat_ready = (state == FR_READ);
    assign xfer       = beat_valid && beat_ready;

    // payload register, flags below qualify it
    always_ff @(posedge clk) begin
        if (xfer) begin
            tx_data <= beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FR_SLEEP;
            counter  <= '0;
            tx_valid <= 1'b0;
            tx_eof   <= 1'b0;
        end else begin
            case (state)
                FR_SLEEP: begin
                    tx_valid <= 1'b0;
                    tx_eof   <= 1'b0;
                    // gap of sleep_cycles+1 cycles
                    if (counter == sleep_cycles) begin
                        counter <= '0;
                        state   <= FR_READ;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end
                FR_READ: begin
                    if (xfer) begin
                        tx_valid <= 1'b1;
                        // counter holds the index of this beat in the packet
                        if (counter == pkt_len) begin
                            tx_eof  <= 1'b1;
                            counter <= '0;
                            state   <= FR_SLEEP;
                        end else begin
                            tx_eof  <= 1'b0;
                            counter <= counter + 1'b1;
                        end
                    end else begin
                        // no data yet, keep waiting
                        tx_valid <= 1'b0;
                        tx_eof   <= 1'b0;
                    end
                end
                default: begin
                    state    <= FR_SLEEP;
                    counter  <= '0;
                    tx_valid <= 1'b0;
                    tx_eof   <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/word_serializer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "tge_defs.svh"

module word_serializer #(
    parameter int DIN_WIDTH  = `TGE_DIN_WIDTH,
    parameter int FIFO_DEPTH = `TGE_FIFO_DEPTH
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [DIN_WIDTH-1:0] din,
    input  wire logic                 din_valid,
    input  wire logic                 beat_ready,
    output tge_pkg::tx_word_t         beat,
    output logic                      beat_valid,
    output logic                      fifo_full
);

    import tge_pkg::*;

    localparam int TX_W      = `TGE_TX_WIDTH;
    localparam int NUM_BEATS = DIN_WIDTH / TX_W;
    localparam int IDX_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

    logic [DIN_WIDTH-1:0] head_word;
    logic                 fifo_empty;
    logic                 fifo_rd;
    logic [IDX_W-1:0]     beat_idx;
    logic                 xfer;
    logic                 last_beat;
    tx_word_t             head_slice;

    sample_fifo #(
        .WIDTH (DIN_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (din),
        .wr      (din_valid),
        .rd      (fifo_rd),
        .rd_data (head_word),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    assign beat_valid = !fifo_empty;
    assign xfer       = beat_valid && beat_ready;
    assign last_beat  = (beat_idx == IDX_W'(NUM_BEATS - 1));

    // head word leaves once its top slice has gone out
    assign fifo_rd = xfer && last_beat;

    // low slice goes first
    assign head_slice = head_word[int'(beat_idx) * TX_W +: TX_W];
    assign beat       = head_slice;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_idx <= '0;
        end else if (xfer) begin
            if (last_beat) begin
                beat_idx <= '0;
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module sample_fifo #(
    parameter int WIDTH = 128,
    parameter int DEPTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [WIDTH-1:0] wr_data,
    input  wire logic             wr,
    input  wire logic             rd,
    output logic      [WIDTH-1:0] rd_data,
    output logic                  empty,
    output logic                  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_wr;
    logic do_rd;

    // requests that cannot be served are ignored
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // first word fall through, head of the queue always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tge_pkg.sv ====
`default_nettype none

`include "tge_defs.svh"

package tge_pkg;

    // one beat handed to the core
    typedef logic [`TGE_TX_WIDTH-1:0] tx_word_t;

    // pkt_len and sleep_cycles values
    typedef logic [31:0] cfg_word_t;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // framer alternates between idle gap and packet release
    typedef enum logic {
        FR_SLEEP = 1'b0,
        FR_READ  = 1'b1
    } framer_state_t;

endpackage

`default_nettype wire

// ==== hdl/tge_defs.svh ====
`ifndef TGE_DEFS_SVH
`define TGE_DEFS_SVH

// wide sample word entering the packetizer, a multiple of the beat width
`define TGE_DIN_WIDTH 128

// beat width toward the 10 GbE core
`define TGE_TX_WIDTH 64

// input words buffered ahead of the serializer, power of two
`define TGE_FIFO_DEPTH 16

`endif
